// File: hw/clic_pkg.sv
// shared widths, csr map, entry layout and enums for the clic rtl and its testbench
`default_nettype none

package clic_pkg;

  // csr data and address
  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // instruction byte address
  localparam int IMEM_ADDR_WIDTH = 16;
  typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;

  // vector table geometry
  localparam int VEC_COUNT       = 8;
  localparam int VEC_INDEX_WIDTH = 3;
  localparam int PRIO_WIDTH      = 3;

  // one stack entry per priority level
  localparam int STACK_DEPTH = 8;
  // depth count must hold STACK_DEPTH itself
  localparam int LEVEL_WIDTH = 4;

  // handler kept as word address, byte address minus two low bits
  localparam int HANDLER_WIDTH = IMEM_ADDR_WIDTH - 2;

  // csr map
  localparam csr_addr_t MINTTHRESH_ADDR  = 12'h347;
  localparam csr_addr_t STACK_LEVEL_ADDR = 12'h350;
  localparam csr_addr_t VEC_CSR_BASE     = 12'hb00;
  localparam csr_addr_t ENTRY_CSR_BASE   = 12'hb20;

  // entry word layout, prio sits in bits 4..2
  localparam int ENTRY_PEND_BIT = 0;
  localparam int ENTRY_EN_BIT   = 1;
  localparam int ENTRY_PRIO_LSB = 2;

  // pc value the core offers to return from an interrupt
  localparam imem_addr_t RETURN_MARKER = '1;

  // csr read-modify-write operation
  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  // dispatcher decision per fetch
  typedef enum logic [1:0] {
    DISP_PASS,
    DISP_TAKE,
    DISP_RETURN,
    DISP_CHAIN
  } dispatch_e;

endpackage

`default_nettype wire

// File: hw/clic_csr_file.sv
// csr register block of the clic: threshold, handler and entry registers, read mux
`timescale 1ns/1ps
`default_nettype none

module clic_csr_file
  import clic_pkg::*;
(
  input  logic                                      clk,
  input  logic                                      rst_n,
  // csr port from the core
  input  logic                                      csr_en,
  input  csr_addr_t                                 csr_addr,
  input  csr_op_e                                   csr_op,
  input  word_t                                     csr_wdata,
  // interrupt lines and stack depth
  input  logic [VEC_COUNT-1:0]                      irq,
  input  logic [LEVEL_WIDTH-1:0]                    level,
  // hardware updates from the dispatcher
  input  logic                                      thresh_we,
  input  logic [PRIO_WIDTH-1:0]                     thresh_wdata,
  input  logic                                      pend_clr,
  input  logic [VEC_INDEX_WIDTH-1:0]                pend_clr_index,
  // outputs
  output word_t                                     csr_rdata,
  output logic [PRIO_WIDTH-1:0]                     thresh,
  output logic [VEC_COUNT-1:0][PRIO_WIDTH-1:0]      entry_prio,
  output logic [VEC_COUNT-1:0]                      entry_en,
  output logic [VEC_COUNT-1:0]                      entry_pend,
  output logic [VEC_COUNT-1:0][HANDLER_WIDTH-1:0]   handler
);

  logic                       sel_thresh;
  logic                       sel_level;
  logic                       sel_vec;
  logic                       sel_entry;
  logic [VEC_INDEX_WIDTH-1:0] sel_index;
  logic                       wr;
  word_t                      new_word;

  // address decode, table blocks are aligned to eight entries
  assign sel_thresh = (csr_addr == MINTTHRESH_ADDR);
  assign sel_level  = (csr_addr == STACK_LEVEL_ADDR);
  assign sel_vec    = (csr_addr[11:VEC_INDEX_WIDTH] == VEC_CSR_BASE[11:VEC_INDEX_WIDTH]);
  assign sel_entry  = (csr_addr[11:VEC_INDEX_WIDTH] == ENTRY_CSR_BASE[11:VEC_INDEX_WIDTH]);
  assign sel_index  = csr_addr[VEC_INDEX_WIDTH-1:0];

  assign wr = csr_en && (csr_op != CSR_NONE);

  // read mux, unmapped reads zero
  always_comb begin
    csr_rdata = '0;
    if (sel_thresh) begin
      csr_rdata[PRIO_WIDTH-1:0] = thresh;
    end else if (sel_level) begin
      csr_rdata[LEVEL_WIDTH-1:0] = level;
    end else if (sel_vec) begin
      csr_rdata[HANDLER_WIDTH-1:0] = handler[sel_index];
    end else if (sel_entry) begin
      csr_rdata[ENTRY_PEND_BIT]                = entry_pend[sel_index];
      csr_rdata[ENTRY_EN_BIT]                  = entry_en[sel_index];
      csr_rdata[ENTRY_PRIO_LSB +: PRIO_WIDTH]  = entry_prio[sel_index];
    end
  end

  // read-modify-write on the value the read mux shows
  always_comb begin
    case (csr_op)
      CSR_RW:  new_word = csr_wdata;
      CSR_RS:  new_word = csr_rdata | csr_wdata;
      CSR_RC:  new_word = csr_rdata & ~csr_wdata;
      default: new_word = csr_rdata;
    endcase
  end

  // threshold, hardware update beats csr write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thresh <= '0;
    end else if (thresh_we) begin
      thresh <= thresh_wdata;
    end else if (wr && sel_thresh) begin
      thresh <= new_word[PRIO_WIDTH-1:0];
    end
  end

  // vector table
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      handler    <= '0;
      entry_prio <= '0;
      entry_en   <= '0;
      entry_pend <= '0;
    end else begin
      for (int k = 0; k < VEC_COUNT; k++) begin
        if (wr && sel_vec && (sel_index == VEC_INDEX_WIDTH'(k))) begin
          handler[k] <= new_word[HANDLER_WIDTH-1:0];
        end
        if (wr && sel_entry && (sel_index == VEC_INDEX_WIDTH'(k))) begin
          entry_prio[k] <= new_word[ENTRY_PRIO_LSB +: PRIO_WIDTH];
          entry_en[k]   <= new_word[ENTRY_EN_BIT];
          entry_pend[k] <= new_word[ENTRY_PEND_BIT];
        end
        // taken vector drops its pending bit
        if (pend_clr && (pend_clr_index == VEC_INDEX_WIDTH'(k))) begin
          entry_pend[k] <= 1'b0;
        end
        // later assignment wins, so a request overrides any clear
        if (irq[k]) begin
          entry_pend[k] <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/clic_prio_select.sv
// picks the enabled pending vector of highest priority above the threshold
`timescale 1ns/1ps
`default_nettype none

module clic_prio_select
  import clic_pkg::*;
(
  input  logic [PRIO_WIDTH-1:0]                     thresh,
  input  logic [VEC_COUNT-1:0][PRIO_WIDTH-1:0]      entry_prio,
  input  logic [VEC_COUNT-1:0]                      entry_en,
  input  logic [VEC_COUNT-1:0]                      entry_pend,
  input  logic [VEC_COUNT-1:0][HANDLER_WIDTH-1:0]   handler,
  output logic                                      irq_hit,
  output logic [VEC_INDEX_WIDTH-1:0]                win_index,
  output logic [PRIO_WIDTH-1:0]                     win_prio,
  output logic [HANDLER_WIDTH-1:0]                  win_handler
);

  logic [PRIO_WIDTH-1:0]      run_prio;
  logic                       run_hit;
  logic [VEC_INDEX_WIDTH-1:0] run_index;

  // running maximum seeded with the threshold
  always_comb begin
    run_prio  = thresh;
    run_hit   = 1'b0;
    run_index = '0;
    for (int k = 0; k < VEC_COUNT; k++) begin
      // strictly greater, so ties keep the lower index
      if (entry_en[k] && entry_pend[k] && (entry_prio[k] > run_prio)) begin
        run_prio  = entry_prio[k];
        run_hit   = 1'b1;
        run_index = VEC_INDEX_WIDTH'(k);
      end
    end
  end

  assign irq_hit   = run_hit;
  assign win_index = run_index;
  // equals thresh when nothing hits
  assign win_prio  = run_prio;

  // handler of the winner
  assign win_handler = handler[run_index];

endmodule

`default_nettype wire

// File: hw/clic_epc_stack.sv
// return address and saved threshold stack for nested interrupts
`timescale 1ns/1ps
`default_nettype none

module clic_epc_stack
  import clic_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  logic                   pop,
  input  imem_addr_t             push_addr,
  input  logic [PRIO_WIDTH-1:0]  push_prio,
  output imem_addr_t             top_addr,
  output logic [PRIO_WIDTH-1:0]  top_prio,
  output logic [LEVEL_WIDTH-1:0] level
);

  imem_addr_t                 addr_mem [STACK_DEPTH];
  logic [PRIO_WIDTH-1:0]      prio_mem [STACK_DEPTH];
  logic [VEC_INDEX_WIDTH-1:0] wr_ptr;
  logic [VEC_INDEX_WIDTH-1:0] top_ptr;

  // write slot is level, top is level minus one
  assign wr_ptr  = level[VEC_INDEX_WIDTH-1:0];
  assign top_ptr = wr_ptr - 1'b1;

  // depth counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else if (push) begin
      level <= level + 1'b1;
    end else if (pop) begin
      level <= level - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      prio_mem[wr_ptr] <= push_prio;
    end
  end

  // top of stack, undefined contents at level zero
  assign top_addr = addr_mem[top_ptr];
  assign top_prio = prio_mem[top_ptr];

endmodule

`default_nettype wire

// File: hw/clic_dispatch.sv
// per-fetch decision between pass, take, return and tail-chain with its side effects
`timescale 1ns/1ps
`default_nettype none

module clic_dispatch
  import clic_pkg::*;
(
  input  logic                       pc_valid,
  input  imem_addr_t                 pc_in,
  // from the selector
  input  logic                       irq_hit,
  input  logic [VEC_INDEX_WIDTH-1:0] win_index,
  input  logic [PRIO_WIDTH-1:0]      win_prio,
  input  logic [HANDLER_WIDTH-1:0]   win_handler,
  input  logic [PRIO_WIDTH-1:0]      thresh,
  // from the stack
  input  imem_addr_t                 top_addr,
  input  logic [PRIO_WIDTH-1:0]      top_prio,
  // redirect
  output imem_addr_t                 pc_out,
  output dispatch_e                  decision,
  // stack control
  output logic                       push,
  output logic                       pop,
  output imem_addr_t                 push_addr,
  output logic [PRIO_WIDTH-1:0]      push_prio,
  // register updates
  output logic                       thresh_we,
  output logic [PRIO_WIDTH-1:0]      thresh_wdata,
  output logic                       pend_clr,
  output logic [VEC_INDEX_WIDTH-1:0] pend_clr_index
);

  logic is_ret;

  assign is_ret = (pc_in == RETURN_MARKER);

  // four-way decision, no strobe means pass
  always_comb begin
    if (!pc_valid) begin
      decision = DISP_PASS;
    end else if (is_ret && irq_hit) begin
      decision = DISP_CHAIN;
    end else if (irq_hit) begin
      decision = DISP_TAKE;
    end else if (is_ret) begin
      decision = DISP_RETURN;
    end else begin
      decision = DISP_PASS;
    end
  end

  // redirect target
  always_comb begin
    case (decision)
      DISP_TAKE, DISP_CHAIN: pc_out = {win_handler, 2'b00};
      DISP_RETURN:           pc_out = top_addr;
      default:               pc_out = pc_in;
    endcase
  end

  // stack only moves on take and return
  assign push      = (decision == DISP_TAKE);
  assign pop       = (decision == DISP_RETURN);
  assign push_addr = pc_in;
  assign push_prio = thresh;

  // take raises to the winner, return restores the saved level
  assign thresh_we    = (decision == DISP_TAKE) || (decision == DISP_RETURN);
  assign thresh_wdata = (decision == DISP_TAKE) ? win_prio : top_prio;

  // winner's pending bit goes on take and chain
  assign pend_clr       = (decision == DISP_TAKE) || (decision == DISP_CHAIN);
  assign pend_clr_index = win_index;

endmodule

`default_nettype wire

// File: hw/clic_top.sv
// clic top level joining csr file, priority selector, epc stack and dispatcher
`timescale 1ns/1ps
`default_nettype none

module clic_top
  import clic_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // csr port
  input  logic                 csr_en,
  input  csr_addr_t            csr_addr,
  input  csr_op_e              csr_op,
  input  word_t                csr_wdata,
  output word_t                csr_rdata,
  // interrupt lines
  input  logic [VEC_COUNT-1:0] irq,
  // fetch port
  input  logic                 pc_valid,
  input  imem_addr_t           pc_in,
  output imem_addr_t           pc_out
);

  // csr file to selector
  logic [PRIO_WIDTH-1:0]                    thresh;
  logic [VEC_COUNT-1:0][PRIO_WIDTH-1:0]     entry_prio;
  logic [VEC_COUNT-1:0]                     entry_en;
  logic [VEC_COUNT-1:0]                     entry_pend;
  logic [VEC_COUNT-1:0][HANDLER_WIDTH-1:0]  handler;

  // selector to dispatcher
  logic                       irq_hit;
  logic [VEC_INDEX_WIDTH-1:0] win_index;
  logic [PRIO_WIDTH-1:0]      win_prio;
  logic [HANDLER_WIDTH-1:0]   win_handler;

  // dispatcher and stack
  logic                       push;
  logic                       pop;
  imem_addr_t                 push_addr;
  logic [PRIO_WIDTH-1:0]      push_prio;
  imem_addr_t                 top_addr;
  logic [PRIO_WIDTH-1:0]      top_prio;
  logic [LEVEL_WIDTH-1:0]     level;

  // dispatcher back to csr file
  logic                       thresh_we;
  logic [PRIO_WIDTH-1:0]      thresh_wdata;
  logic                       pend_clr;
  logic [VEC_INDEX_WIDTH-1:0] pend_clr_index;
  // visible for bound checks
  dispatch_e                  decision;

  clic_csr_file csr_file_i (
    .clk, .rst_n,
    .csr_en, .csr_addr, .csr_op, .csr_wdata,
    .irq, .level,
    .thresh_we, .thresh_wdata, .pend_clr, .pend_clr_index,
    .csr_rdata, .thresh,
    .entry_prio, .entry_en, .entry_pend, .handler
  );

  clic_prio_select prio_select_i (
    .thresh, .entry_prio, .entry_en, .entry_pend, .handler,
    .irq_hit, .win_index, .win_prio, .win_handler
  );

  clic_epc_stack epc_stack_i (
    .clk, .rst_n,
    .push, .pop, .push_addr, .push_prio,
    .top_addr, .top_prio, .level
  );

  clic_dispatch dispatch_i (
    .pc_valid, .pc_in,
    .irq_hit, .win_index, .win_prio, .win_handler, .thresh,
    .top_addr, .top_prio,
    .pc_out, .decision,
    .push, .pop, .push_addr, .push_prio,
    .thresh_we, .thresh_wdata, .pend_clr, .pend_clr_index
  );

endmodule

`default_nettype wire

// File: sim/clic_assertions.sv
// concurrent checks on stack use and dispatch decisions, bound into clic_top
`timescale 1ns/1ps
`default_nettype none

module clic_assertions
  import clic_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   push,
  input logic                   pop,
  input logic [LEVEL_WIDTH-1:0] level,
  input dispatch_e              decision
);

  // failed checks so far
  int violations = 0;

  // pop needs a saved entry
  no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (level != '0))
    else begin
      $error("pop with the stack at level zero");
      violations = violations + 1;
    end

  // push needs a free slot
  no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (level != LEVEL_WIDTH'(STACK_DEPTH)))
    else begin
      $error("push with the stack full");
      violations = violations + 1;
    end

  no_push_and_pop: assert property (@(posedge clk) disable iff (!rst_n)
    !(push && pop))
    else begin
      $error("push and pop in the same cycle");
      violations = violations + 1;
    end

  // a take leaves one more saved entry
  take_grows_stack: assert property (@(posedge clk) disable iff (!rst_n)
    (decision == DISP_TAKE) |=> (level == $past(level) + 1'b1))
    else begin
      $error("take did not raise the stack level by one");
      violations = violations + 1;
    end

endmodule

bind clic_top clic_assertions assertions_i (
  .clk, .rst_n, .push, .pop, .level, .decision
);

`default_nettype wire

// File: sim/clic_tb.sv
// testbench for clic_top, applies a stimulus table and checks csr reads and fetch redirects
`timescale 1ns/1ps
`default_nettype none

module clic_tb
  import clic_pkg::*;
();

  // row kinds of the stimulus table
  typedef enum logic [1:0] {
    ROW_CSR,
    ROW_FETCH,
    ROW_IDLE,
    ROW_IRQ
  } row_kind_e;

  // data holds wdata, pc or irq mask depending on kind
  typedef struct packed {
    row_kind_e kind;
    csr_addr_t addr;
    csr_op_e   op;
    word_t     data;
    word_t     expect_val;
    logic      check;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 csr_en;
  csr_addr_t            csr_addr;
  csr_op_e              csr_op;
  word_t                csr_wdata;
  word_t                csr_rdata;
  logic [VEC_COUNT-1:0] irq;
  logic                 pc_valid;
  imem_addr_t           pc_in;
  imem_addr_t           pc_out;

  row_t rows[$];
  int   errors = 0;
  int   n_checks = 0;
  int   asserts = 0;
  int   cycles = 0;
  int   limit = 0;

  clic_top clic_top_i (
    .clk, .rst_n,
    .csr_en, .csr_addr, .csr_op, .csr_wdata, .csr_rdata,
    .irq,
    .pc_valid, .pc_in, .pc_out
  );

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  // run guard, limit set once the table is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, stimulus table did not finish", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic void add_row(row_kind_e k, csr_addr_t a, csr_op_e op, word_t d,
                                  word_t e, logic c);
    row_t r;
    r.kind       = k;
    r.addr       = a;
    r.op         = op;
    r.data       = d;
    r.expect_val = e;
    r.check      = c;
    rows.push_back(r);
  endfunction

  function automatic void add_write(csr_addr_t a, csr_op_e op, word_t d);
    add_row(ROW_CSR, a, op, d, '0, 1'b0);
  endfunction

  // read is a csr strobe with no operation
  function automatic void add_read(csr_addr_t a, word_t e);
    add_row(ROW_CSR, a, CSR_NONE, '0, e, 1'b1);
  endfunction

  function automatic void add_fetch(word_t pc, word_t e);
    add_row(ROW_FETCH, '0, CSR_NONE, pc, e, 1'b1);
  endfunction

  // pc offered with pc_valid low
  function automatic void add_idle(word_t pc);
    add_row(ROW_IDLE, '0, CSR_NONE, pc, pc, 1'b1);
  endfunction

  function automatic void add_irq(word_t mask);
    add_row(ROW_IRQ, '0, CSR_NONE, mask, '0, 1'b0);
  endfunction

  task automatic drive_row(input row_t r);
    csr_en    <= (r.kind == ROW_CSR);
    csr_addr  <= r.addr;
    csr_op    <= r.op;
    csr_wdata <= (r.kind == ROW_CSR) ? r.data : '0;
    pc_valid  <= (r.kind == ROW_FETCH);
    pc_in     <= (r.kind == ROW_FETCH || r.kind == ROW_IDLE) ?
                 r.data[IMEM_ADDR_WIDTH-1:0] : '0;
    irq       <= (r.kind == ROW_IRQ) ? r.data[VEC_COUNT-1:0] : '0;
  endtask

  task automatic check_word(input word_t got, input word_t exp, input int idx);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: row %0d csr_rdata %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_pc(input imem_addr_t got, input imem_addr_t exp, input int idx);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: row %0d pc_out %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic build_table();
    // handler register rw, rs, rc, 14 bits kept
    add_write(12'hb00, CSR_RW, 32'hffff_1234);
    add_read(12'hb00, 32'h0000_1234);
    add_write(12'hb00, CSR_RS, 32'h0000_c00b);
    add_read(12'hb00, 32'h0000_123f);
    add_write(12'hb00, CSR_RC, 32'h0000_0030);
    add_read(12'hb00, 32'h0000_120f);
    // entry register, 5 bits kept
    add_write(12'hb21, CSR_RW, 32'hffff_ffe6);
    add_read(12'hb21, 32'h0000_0006);
    add_write(12'hb21, CSR_RS, 32'h0000_0018);
    add_read(12'hb21, 32'h0000_001e);
    add_write(12'hb21, CSR_RC, 32'h0000_001e);
    add_read(12'hb21, 32'h0000_0000);
    // threshold, 3 bits kept
    add_write(12'h347, CSR_RW, 32'hffff_fffd);
    add_read(12'h347, 32'h0000_0005);
    add_write(12'h347, CSR_RS, 32'h0000_0002);
    add_read(12'h347, 32'h0000_0007);
    add_write(12'h347, CSR_RC, 32'h0000_0006);
    add_read(12'h347, 32'h0000_0001);
    add_write(12'h347, CSR_RW, 32'h0000_0000);
    add_read(12'h347, 32'h0000_0000);
    // stack level ignores writes, unmapped reads zero
    add_write(12'h350, CSR_RW, 32'h0000_00ff);
    add_read(12'h350, 32'h0000_0000);
    add_write(12'h123, CSR_RW, 32'hdead_beef);
    add_read(12'h123, 32'h0000_0000);
    add_read(12'hb10, 32'h0000_0000);
    // vec 3 pending but disabled, vec 2 pending at prio 0
    add_write(12'hb23, CSR_RW, 32'h0000_001d);
    add_read(12'hb23, 32'h0000_001d);
    add_write(12'hb22, CSR_RW, 32'h0000_0003);
    // handlers and entries for the interrupt part
    add_write(12'hb04, CSR_RW, 32'h0000_0400);
    add_write(12'hb05, CSR_RW, 32'h0000_0500);
    add_write(12'hb06, CSR_RW, 32'h0000_0600);
    add_write(12'hb01, CSR_RW, 32'h0000_0100);
    add_write(12'hb24, CSR_RW, 32'h0000_000e);
    add_write(12'hb25, CSR_RW, 32'h0000_000e);
    add_write(12'hb26, CSR_RW, 32'h0000_001a);
    add_write(12'hb21, CSR_RW, 32'h0000_000a);
    // pass through, nothing enabled above the threshold
    add_fetch(32'h0000_0100, 32'h0000_0100);
    add_idle(32'h0000_ffff);
    add_read(12'h350, 32'h0000_0000);
    // tie at prio 3, vec 4 wins
    add_irq(32'h0000_0030);
    add_read(12'hb24, 32'h0000_000f);
    add_read(12'hb25, 32'h0000_000f);
    add_fetch(32'h0000_0200, 32'h0000_1000);
    add_read(12'h347, 32'h0000_0003);
    add_read(12'h350, 32'h0000_0001);
    add_read(12'hb24, 32'h0000_000e);
    add_read(12'hb25, 32'h0000_000f);
    // vec 6 preempts the handler
    add_fetch(32'h0000_1000, 32'h0000_1000);
    add_irq(32'h0000_0040);
    add_fetch(32'h0000_1004, 32'h0000_1800);
    add_read(12'h350, 32'h0000_0002);
    add_read(12'h347, 32'h0000_0006);
    add_read(12'hb26, 32'h0000_001a);
    // unwind in reverse order
    add_fetch(32'h0000_ffff, 32'h0000_1004);
    add_read(12'h347, 32'h0000_0003);
    add_read(12'h350, 32'h0000_0001);
    add_fetch(32'h0000_ffff, 32'h0000_0200);
    add_read(12'h347, 32'h0000_0000);
    add_read(12'h350, 32'h0000_0000);
    // vec 5 still pending, then tail-chain into vec 6
    add_fetch(32'h0000_0300, 32'h0000_1400);
    add_read(12'h347, 32'h0000_0003);
    add_irq(32'h0000_0040);
    add_fetch(32'h0000_ffff, 32'h0000_1800);
    add_read(12'h350, 32'h0000_0001);
    add_read(12'h347, 32'h0000_0003);
    add_read(12'hb26, 32'h0000_001a);
    add_fetch(32'h0000_ffff, 32'h0000_0300);
    add_read(12'h350, 32'h0000_0000);
    add_read(12'h347, 32'h0000_0000);
    // irq line on vec 1, disabled vec 3 left untouched
    add_irq(32'h0000_0002);
    add_read(12'hb21, 32'h0000_000b);
    add_fetch(32'h0000_0500, 32'h0000_0400);
    add_fetch(32'h0000_ffff, 32'h0000_0500);
    add_read(12'hb23, 32'h0000_001d);
    add_read(12'h350, 32'h0000_0000);
  endtask

  initial begin
    rst_n     = 1'b0;
    csr_en    = 1'b0;
    csr_addr  = '0;
    csr_op    = CSR_NONE;
    csr_wdata = '0;
    irq       = '0;
    pc_valid  = 1'b0;
    pc_in     = '0;
    build_table();
    limit = rows.size() * 4 + 50;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      drive_row(rows[i]);
      // outputs are combinational, settled by the falling edge
      @(negedge clk);
      if (rows[i].check) begin
        if (rows[i].kind == ROW_CSR) begin
          check_word(csr_rdata, rows[i].expect_val, i);
        end else begin
          check_pc(pc_out, rows[i].expect_val[IMEM_ADDR_WIDTH-1:0], i);
        end
      end
    end
    @(posedge clk);
    csr_en   <= 1'b0;
    pc_valid <= 1'b0;
    irq      <= '0;
    @(posedge clk);
    asserts = clic_top_i.assertions_i.violations;
    $display("checks %0d, errors %0d, assertion failures %0d", n_checks, errors, asserts);
    if (errors == 0 && asserts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/clic_pkg.sv
hw/clic_csr_file.sv
hw/clic_prio_select.sv
hw/clic_epc_stack.sv
hw/clic_dispatch.sv
hw/clic_top.sv
sim/clic_assertions.sv
sim/clic_tb.sv

// File: Makefile
.PHONY: all lint clean

all: obj_dir/Vclic_tb
	@out="$$(./obj_dir/Vclic_tb)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

obj_dir/Vclic_tb: tb.f hw/*.sv sim/*.sv
	verilator --binary --timing --assert -f tb.f --top-module clic_tb

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module clic_tb

clean:
	rm -rf obj_dir
